// ==== hw/tenyr_bus_settings.svh ====
`ifndef TENYR_BUS_SETTINGS_SVH
`define TENYR_BUS_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Data bus address map
// ---------------------------------------------------------------------------

// All addresses are word addresses, so one step moves by a 32-bit word

// Main memory sits at the reset vector and covers 1024 words
`define RESETVECTOR     32'h00001000
`define RAM_MASK        32'hfffffc00

// Word-address width of the RAM, which must agree with RAM_MASK
`define RAM_ABITS       10

// The seven-segment display decodes two registers
`define SEG7_ADDR       32'h00000100
`define SEG7_MASK       32'hfffffffe

// ---------------------------------------------------------------------------
// Display scanning
// ---------------------------------------------------------------------------

// Each digit stays lit for 2**SEG7_SCAN_BITS clock cycles
// A board build at a real core clock would raise this to roughly 16
`define SEG7_SCAN_BITS  4

`endif

// ==== hw/tenyr_bus_pkg.sv ====
package tenyr_bus_pkg;

    // -----------------------------------------------------------------------
    // Bus types
    // -----------------------------------------------------------------------

    // Number of byte lanes in one bus word
    localparam int BUS_BYTES = 4;

    // Data and address word of the tenyr data bus
    typedef logic [8*BUS_BYTES-1:0] bus_word_t;

    // One select bit per byte lane, bit 0 selects bits 7 to 0
    typedef logic [BUS_BYTES-1:0] bus_sel_t;

    // -----------------------------------------------------------------------
    // Display types
    // -----------------------------------------------------------------------

    // Number of digits on the display
    localparam int NUM_DIGITS = 4;

    // A single hex digit as written by software
    typedef logic [3:0] digit_t;

    // Segment pattern driven to the pins, active low
    // Bit 7 is the decimal point, bits 6 to 0 are segments g down to a
    typedef logic [7:0] seg_pattern_t;

    // Pattern with every segment and the decimal point dark
    localparam seg_pattern_t SEG_BLANK = 8'hff;

endpackage

// ==== hw/wb_mux.sv ====
`timescale 1ns/10ps

module wb_mux #(
    parameter int NUM_SLAVES = 2,
    parameter tenyr_bus_pkg::bus_word_t [NUM_SLAVES-1:0] MATCH_ADDR = '0,
    parameter tenyr_bus_pkg::bus_word_t [NUM_SLAVES-1:0] MATCH_MASK = '0
) (
    input  logic                                        wb_clk_i,
    input  logic                                        rst_i,

    // Master side
    input  tenyr_bus_pkg::bus_word_t                    wbm_adr_i,
    input  tenyr_bus_pkg::bus_word_t                    wbm_dat_i,
    output tenyr_bus_pkg::bus_word_t                    wbm_dat_o,
    input  logic                                        wbm_we_i,
    input  tenyr_bus_pkg::bus_sel_t                     wbm_sel_i,
    input  logic                                        wbm_stb_i,
    input  logic                                        wbm_cyc_i,
    output logic                                        wbm_ack_o,

    // Slave side, index 0 has the highest decode priority
    output tenyr_bus_pkg::bus_word_t [NUM_SLAVES-1:0]   wbs_adr_o,
    output tenyr_bus_pkg::bus_word_t [NUM_SLAVES-1:0]   wbs_dat_o,
    input  tenyr_bus_pkg::bus_word_t [NUM_SLAVES-1:0]   wbs_dat_i,
    output logic [NUM_SLAVES-1:0]                       wbs_we_o,
    output tenyr_bus_pkg::bus_sel_t [NUM_SLAVES-1:0]    wbs_sel_o,
    output logic [NUM_SLAVES-1:0]                       wbs_stb_o,
    output logic [NUM_SLAVES-1:0]                       wbs_cyc_o,
    input  logic [NUM_SLAVES-1:0]                       wbs_ack_i
);

    logic [NUM_SLAVES-1:0] slave_sel;
    logic                  hit;
    logic                  def_stb;
    logic                  def_ack;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    // First match wins, so later slaves are only taken when no earlier one hits
    always_comb begin
        slave_sel = '0;
        hit       = 1'b0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (!hit && ((wbm_adr_i & MATCH_MASK[i]) == (MATCH_ADDR[i] & MATCH_MASK[i]))) begin
                slave_sel[i] = 1'b1;
                hit          = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Request routing
    // ------------------------------------------------------------------------

    // Only the selected slave sees the request, with the matched base removed
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            wbs_adr_o[i] = slave_sel[i] ? (wbm_adr_i & ~MATCH_MASK[i]) : '0;
            wbs_dat_o[i] = slave_sel[i] ? wbm_dat_i : '0;
            wbs_sel_o[i] = slave_sel[i] ? wbm_sel_i : '0;
            wbs_we_o[i]  = slave_sel[i] & wbm_we_i;
            wbs_stb_o[i] = slave_sel[i] & wbm_stb_i;
            wbs_cyc_o[i] = slave_sel[i] & wbm_cyc_i;
        end
    end

    // ------------------------------------------------------------------------
    // Default slave
    // ------------------------------------------------------------------------

    // Unmapped accesses get a single-cycle ack, and writes go nowhere
    assign def_stb = wbm_stb_i & wbm_cyc_i & ~hit;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            def_ack <= 1'b0;
        end else begin
            def_ack <= def_stb & ~def_ack;
        end
    end

    // ------------------------------------------------------------------------
    // Response multiplexer
    // ------------------------------------------------------------------------

    // The default slave reads as all ones
    always_comb begin
        wbm_dat_o = '1;
        wbm_ack_o = def_ack;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (slave_sel[i]) begin
                wbm_dat_o = wbs_dat_i[i];
                wbm_ack_o = wbs_ack_i[i];
            end
        end
    end

    // Two responders acking together would mean a slave answered a request it never saw
    a_one_ack: assert property (
        @(posedge wb_clk_i) disable iff (rst_i) $onehot0({def_ack, wbs_ack_i})
    );

endmodule

// ==== hw/block_ram.sv ====
`include "tenyr_bus_settings.svh"
`timescale 1ns/10ps

module block_ram #(
    parameter int ABITS = `RAM_ABITS
) (
    input  logic                        wb_clk_i,
    input  logic                        rst_i,
    input  tenyr_bus_pkg::bus_word_t    adr_i,
    input  tenyr_bus_pkg::bus_word_t    dat_i,
    output tenyr_bus_pkg::bus_word_t    dat_o,
    input  logic                        we_i,
    input  tenyr_bus_pkg::bus_sel_t     sel_i,
    input  logic                        stb_i,
    input  logic                        cyc_i,
    output logic                        ack_o
);

    import tenyr_bus_pkg::*;

    localparam int DEPTH = 1 << ABITS;

    bus_word_t        mem [DEPTH];
    logic [ABITS-1:0] word_adr;
    logic             req;

    // Only the offset inside the RAM window reaches the array
    assign word_adr = adr_i[ABITS-1:0];

    // A new request is taken only while no ack is pending
    assign req = stb_i & cyc_i & ~ack_o;

    // ------------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------------

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // Writes land on the same edge that raises ack
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            if (we_i) begin
                for (int b = 0; b < BUS_BYTES; b++) begin
                    if (sel_i[b]) begin
                        mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            dat_o <= mem[word_adr];
        end
    end

    // A strobed request must carry a known address, direction and lane mask
    a_known_req: assert property (
        @(posedge wb_clk_i) disable iff (rst_i)
        (stb_i && cyc_i) |-> !$isunknown({adr_i, we_i, sel_i})
    );

endmodule

// ==== hw/seg7_regs.sv ====
`timescale 1ns/10ps

module seg7_regs (
    input  logic                                            wb_clk_i,
    input  logic                                            rst_i,
    input  tenyr_bus_pkg::bus_word_t                        adr_i,
    input  tenyr_bus_pkg::bus_word_t                        dat_i,
    output tenyr_bus_pkg::bus_word_t                        dat_o,
    input  logic                                            we_i,
    input  logic                                            stb_i,
    input  logic                                            cyc_i,
    output logic                                            ack_o,
    output tenyr_bus_pkg::digit_t [tenyr_bus_pkg::NUM_DIGITS-1:0] digits_o,
    output logic [tenyr_bus_pkg::NUM_DIGITS-1:0]            dp_o,
    output logic                                            enable_o
);

    logic req;
    logic ctrl_sel;

    // Offset 0 is the digit register, offset 1 the control register
    assign ctrl_sel = adr_i[0];

    assign req = stb_i & cyc_i & ~ack_o;

    // ------------------------------------------------------------------------
    // Control register and acknowledge
    // ------------------------------------------------------------------------

    // Control holds enable in bit 0 and the decimal points in bits 7 to 4
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o    <= 1'b0;
            enable_o <= 1'b0;
            dp_o     <= '0;
        end else begin
            ack_o <= req;
            if (req && we_i && ctrl_sel) begin
                enable_o <= dat_i[0];
                dp_o     <= dat_i[7:4];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Digit register and read data
    // ------------------------------------------------------------------------

    // Digit 0 sits in the lowest nibble
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            if (we_i && !ctrl_sel) begin
                digits_o <= dat_i[15:0];
            end
            if (ctrl_sel) begin
                dat_o <= {24'h000000, dp_o, 3'b000, enable_o};
            end else begin
                dat_o <= {16'h0000, digits_o};
            end
        end
    end

endmodule

// ==== hw/seg7_scan.sv ====
`include "tenyr_bus_settings.svh"
`timescale 1ns/10ps

module seg7_scan (
    input  logic                                            wb_clk_i,
    input  logic                                            rst_i,
    input  tenyr_bus_pkg::digit_t [tenyr_bus_pkg::NUM_DIGITS-1:0] digits_i,
    input  logic [tenyr_bus_pkg::NUM_DIGITS-1:0]            dp_i,
    input  logic                                            enable_i,
    output tenyr_bus_pkg::seg_pattern_t                     seg_o,
    output logic [tenyr_bus_pkg::NUM_DIGITS-1:0]            an_o
);

    import tenyr_bus_pkg::*;

    logic [`SEG7_SCAN_BITS-1:0] prescale;
    logic [1:0]                 digit_sel;
    seg_pattern_t               pattern;

    // Standard common-anode patterns, segment a in bit 0
    function automatic seg_pattern_t hex_to_seg(input digit_t value);
        case (value)
            4'h0: hex_to_seg = 8'hc0;
            4'h1: hex_to_seg = 8'hf9;
            4'h2: hex_to_seg = 8'ha4;
            4'h3: hex_to_seg = 8'hb0;
            4'h4: hex_to_seg = 8'h99;
            4'h5: hex_to_seg = 8'h92;
            4'h6: hex_to_seg = 8'h82;
            4'h7: hex_to_seg = 8'hf8;
            4'h8: hex_to_seg = 8'h80;
            4'h9: hex_to_seg = 8'h90;
            4'ha: hex_to_seg = 8'h88;
            4'hb: hex_to_seg = 8'h83;
            4'hc: hex_to_seg = 8'hc6;
            4'hd: hex_to_seg = 8'ha1;
            4'he: hex_to_seg = 8'h86;
            default: hex_to_seg = 8'h8e;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Digit scan counter
    // ------------------------------------------------------------------------

    // The digit moves on each time the prescaler wraps
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            prescale  <= '0;
            digit_sel <= '0;
        end else begin
            prescale <= prescale + 1'b1;
            if (&prescale) begin
                digit_sel <= digit_sel + 1'b1;
            end
        end
    end

    // A set decimal point pulls bit 7 low
    always_comb begin
        pattern    = hex_to_seg(digits_i[digit_sel]);
        pattern[7] = ~dp_i[digit_sel];
    end

    // ------------------------------------------------------------------------
    // Pin drivers
    // ------------------------------------------------------------------------

    always_ff @(posedge wb_clk_i) begin
        if (rst_i || !enable_i) begin
            an_o  <= '1;
            seg_o <= SEG_BLANK;
        end else begin
            an_o  <= ~(4'b0001 << digit_sel);
            seg_o <= pattern;
        end
    end

    // A lit digit must never show a pattern built from unwritten digit bits
    a_known_seg: assert property (
        @(posedge wb_clk_i) disable iff (rst_i) (an_o != '1) |-> !$isunknown(seg_o)
    );

endmodule

// ==== hw/tenyr_bus_top.sv ====
`include "tenyr_bus_settings.svh"
`timescale 1ns/10ps

module tenyr_bus_top (
    input  logic                                    wb_clk_i,
    input  logic                                    rst_i,
    input  tenyr_bus_pkg::bus_word_t                wbm_adr_i,
    input  tenyr_bus_pkg::bus_word_t                wbm_dat_i,
    output tenyr_bus_pkg::bus_word_t                wbm_dat_o,
    input  logic                                    wbm_we_i,
    input  tenyr_bus_pkg::bus_sel_t                 wbm_sel_i,
    input  logic                                    wbm_stb_i,
    input  logic                                    wbm_cyc_i,
    output logic                                    wbm_ack_o,
    output tenyr_bus_pkg::seg_pattern_t             seg_o,
    output logic [tenyr_bus_pkg::NUM_DIGITS-1:0]    an_o
);

    import tenyr_bus_pkg::*;

    // Slave 0 is the display, slave 1 the RAM
    localparam int NUM_SLAVES = 2;

    bus_word_t [NUM_SLAVES-1:0] s_adr;
    bus_word_t [NUM_SLAVES-1:0] s_ddn;
    bus_word_t [NUM_SLAVES-1:0] s_dup;
    bus_sel_t  [NUM_SLAVES-1:0] s_sel;
    logic      [NUM_SLAVES-1:0] s_we;
    logic      [NUM_SLAVES-1:0] s_stb;
    logic      [NUM_SLAVES-1:0] s_cyc;
    logic      [NUM_SLAVES-1:0] s_ack;

    digit_t [NUM_DIGITS-1:0]    digits;
    logic   [NUM_DIGITS-1:0]    dp;
    logic                       enable;

    // ------------------------------------------------------------------------
    // Bus fabric
    // ------------------------------------------------------------------------

    wb_mux #(
        .NUM_SLAVES (NUM_SLAVES),
        .MATCH_ADDR ({`RESETVECTOR, `SEG7_ADDR}),
        .MATCH_MASK ({`RAM_MASK,    `SEG7_MASK})
    ) wb_mux_inst (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .wbm_adr_i (wbm_adr_i),
        .wbm_dat_i (wbm_dat_i),
        .wbm_dat_o (wbm_dat_o),
        .wbm_we_i  (wbm_we_i),
        .wbm_sel_i (wbm_sel_i),
        .wbm_stb_i (wbm_stb_i),
        .wbm_cyc_i (wbm_cyc_i),
        .wbm_ack_o (wbm_ack_o),
        .wbs_adr_o (s_adr),
        .wbs_dat_o (s_ddn),
        .wbs_dat_i (s_dup),
        .wbs_we_o  (s_we),
        .wbs_sel_o (s_sel),
        .wbs_stb_o (s_stb),
        .wbs_cyc_o (s_cyc),
        .wbs_ack_i (s_ack)
    );

    // ------------------------------------------------------------------------
    // Memory and display
    // ------------------------------------------------------------------------

    block_ram #(.ABITS(`RAM_ABITS)) block_ram_inst (
        .wb_clk_i (wb_clk_i), .rst_i (rst_i),
        .adr_i (s_adr[1]), .dat_i (s_ddn[1]), .dat_o (s_dup[1]),
        .we_i  (s_we[1]),  .sel_i (s_sel[1]),
        .stb_i (s_stb[1]), .cyc_i (s_cyc[1]), .ack_o (s_ack[1])
    );

    // The display registers are word wide, so the byte selects stay unused
    seg7_regs seg7_regs_inst (
        .wb_clk_i (wb_clk_i), .rst_i (rst_i),
        .adr_i (s_adr[0]), .dat_i (s_ddn[0]), .dat_o (s_dup[0]),
        .we_i  (s_we[0]),  .stb_i (s_stb[0]), .cyc_i (s_cyc[0]),
        .ack_o (s_ack[0]),
        .digits_o (digits), .dp_o (dp), .enable_o (enable)
    );

    seg7_scan seg7_scan_inst (
        .wb_clk_i (wb_clk_i), .rst_i (rst_i),
        .digits_i (digits), .dp_i (dp), .enable_i (enable),
        .seg_o    (seg_o),  .an_o (an_o)
    );

endmodule

// ==== tb/tb_tenyr_bus.sv ====
`include "tenyr_bus_settings.svh"
`timescale 1ns/10ps

module tb_tenyr_bus;

    import tenyr_bus_pkg::*;

    localparam int          SEED         = 32'hc875;
    localparam int          ACK_TIMEOUT  = 20;
    localparam int          SCAN_TIMEOUT = 100;
    localparam int          BLANK_CYCLES = 80;
    localparam bus_word_t   DISP_DIGITS  = 32'h5a5a_c3e7;
    localparam bus_word_t   DISP_CTRL    = 32'h1234_5a5b;

    // Common-anode patterns for digits F down to 0, segment a in bit 0
    localparam logic [16*8-1:0] SEG_ROM = {
        8'h8e, 8'h86, 8'ha1, 8'hc6, 8'h83, 8'h88, 8'h90, 8'h80,
        8'hf8, 8'h82, 8'h92, 8'h99, 8'hb0, 8'ha4, 8'hf9, 8'hc0
    };

    logic          wb_clk_i = 1'b0;
    logic          rst_i;
    bus_word_t     wbm_adr_i;
    bus_word_t     wbm_dat_i;
    bus_word_t     wbm_dat_o;
    logic          wbm_we_i;
    bus_sel_t      wbm_sel_i;
    logic          wbm_stb_i;
    logic          wbm_cyc_i;
    logic          wbm_ack_o;
    seg_pattern_t  seg_o;
    logic [3:0]    an_o;

    // Stimulus table, one entry per row in each queue
    string         t_name[$];
    logic          t_write[$];
    bus_word_t     t_adr[$];
    bus_sel_t      t_sel[$];
    bus_word_t     t_wdata[$];
    bus_word_t     t_expect[$];

    int            test_errors = 0;
    int            pass_count = 0;
    int            fail_count = 0;
    int            seed_ret;
    logic          ok;
    bus_word_t     rdata;
    bus_word_t     data_a;
    bus_word_t     data_b;
    bus_word_t     data_p;
    bus_word_t     adr_a;
    bus_word_t     adr_b;

    tenyr_bus_top tenyr_bus_top_inst (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .wbm_adr_i (wbm_adr_i),
        .wbm_dat_i (wbm_dat_i),
        .wbm_dat_o (wbm_dat_o),
        .wbm_we_i  (wbm_we_i),
        .wbm_sel_i (wbm_sel_i),
        .wbm_stb_i (wbm_stb_i),
        .wbm_cyc_i (wbm_cyc_i),
        .wbm_ack_o (wbm_ack_o),
        .seg_o     (seg_o),
        .an_o      (an_o)
    );

    always #50 wb_clk_i = ~wb_clk_i;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic compare_value(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
        test_errors = 0;
    endtask

    task automatic add_row(input string name, input logic write, input bus_word_t adr,
                           input bus_sel_t sel, input bus_word_t wdata, input bus_word_t exp);
        t_name.push_back(name);
        t_write.push_back(write);
        t_adr.push_back(adr);
        t_sel.push_back(sel);
        t_wdata.push_back(wdata);
        t_expect.push_back(exp);
    endtask

    // One Wishbone classic transfer, stb drops on the edge that sees ack
    task automatic bus_transfer(input logic write, input bus_word_t adr, input bus_sel_t sel,
                                input bus_word_t wdata, output bus_word_t data,
                                output logic acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        data   = '0;
        @(negedge wb_clk_i);
        wbm_adr_i = adr;
        wbm_dat_i = wdata;
        wbm_sel_i = sel;
        wbm_we_i  = write;
        wbm_stb_i = 1'b1;
        wbm_cyc_i = 1'b1;
        while (!acked && waited < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            waited++;
            if (wbm_ack_o) begin
                acked = 1'b1;
                data  = wbm_dat_o;
            end
        end
        wbm_stb_i = 1'b0;
        wbm_cyc_i = 1'b0;
        wbm_we_i  = 1'b0;
        if (!acked) begin
            $display("TIMEOUT: no ack from address %h within %0d cycles", adr, ACK_TIMEOUT);
        end
    endtask

    // Waits for each anode in turn and checks the pattern it shows
    task automatic check_scan();
        logic [3:0] want;
        logic       found;
        int         waited;
        logic [3:0] dig;
        for (int i = 0; i < 4; i++) begin
            want   = ~(4'b0001 << i);
            found  = 1'b0;
            waited = 0;
            dig    = DISP_DIGITS[4*i +: 4];
            while (!found && waited < SCAN_TIMEOUT) begin
                @(negedge wb_clk_i);
                waited++;
                found = (an_o === want);
            end
            if (!found) begin
                $display("Digit %0d was never lit within %0d cycles", i, SCAN_TIMEOUT);
                test_errors++;
            end else begin
                compare_value($sformatf("scan_digit%0d", i),
                              SEG_ROM[8*dig +: 8] & ~{DISP_CTRL[4+i], 7'b0}, seg_o);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed_ret  = $urandom(SEED);
        rst_i     = 1'b1;
        wbm_adr_i = '0;
        wbm_dat_i = '0;
        wbm_we_i  = 1'b0;
        wbm_sel_i = '0;
        wbm_stb_i = 1'b0;
        wbm_cyc_i = 1'b0;

        // Two distinct RAM words, the second differs in at least one address bit
        adr_a  = `RESETVECTOR + $urandom_range((1 << `RAM_ABITS) - 1, 0);
        adr_b  = adr_a ^ $urandom_range((1 << `RAM_ABITS) - 1, 1);
        data_a = $urandom;
        data_b = $urandom;
        data_p = $urandom;

        add_row("ram_wr_a",     1'b1, adr_a, 4'hf, data_a, '0);
        add_row("ram_wr_b",     1'b1, adr_b, 4'hf, data_b, '0);
        add_row("ram_rd_a",     1'b0, adr_a, 4'hf, '0, data_a);
        add_row("ram_rd_b",     1'b0, adr_b, 4'hf, '0, data_b);
        add_row("ram_part_wr",  1'b1, adr_a, 4'b0101, data_p, '0);
        add_row("ram_part_rd",  1'b0, adr_a, 4'hf, '0,
                {data_a[31:24], data_p[23:16], data_a[15:8], data_p[7:0]});
        add_row("seg_wr_dig",   1'b1, `SEG7_ADDR, 4'hf, DISP_DIGITS, '0);
        add_row("seg_rd_dig",   1'b0, `SEG7_ADDR, 4'hf, '0, {16'h0, DISP_DIGITS[15:0]});
        add_row("seg_wr_ctl",   1'b1, `SEG7_ADDR + 1, 4'hf, DISP_CTRL, '0);
        add_row("seg_rd_ctl",   1'b0, `SEG7_ADDR + 1, 4'hf, '0,
                {24'h0, DISP_CTRL[7:4], 3'b000, DISP_CTRL[0]})
;
        add_row("unmap_rd_zero", 1'b0, 32'h0000_0000, 4'hf, '0, 32'hffff_ffff);
        add_row("unmap_rd_high", 1'b0, 32'hdead_0000, 4'hf, '0, 32'hffff_ffff);
        add_row("unmap_rd_seg2", 1'b0, `SEG7_ADDR + 2, 4'hf, '0, 32'hffff_ffff);
        add_row("unmap_rd_seg3", 1'b0, `SEG7_ADDR + 3, 4'hf, '0, 32'hffff_ffff);
        // One RAM size above adr_a, so a loose RAM decode would land on adr_a itself
        add_row("unmap_wr_ram", 1'b1, adr_a + 32'h400, 4'hf, 32'h1234_5678, '0);
        add_row("unmap_wr_seg", 1'b1, `SEG7_ADDR + 2, 4'hf, 32'h0, '0);
        add_row("keep_ram_a",   1'b0, adr_a, 4'hf, '0,
                {data_a[31:24], data_p[23:16], data_a[15:8], data_p[7:0]});
        add_row("keep_seg_dig", 1'b0, `SEG7_ADDR, 4'hf, '0, {16'h0, DISP_DIGITS[15:0]});
        add_row("keep_seg_ctl", 1'b0, `SEG7_ADDR + 1, 4'hf, '0,
                {24'h0, DISP_CTRL[7:4], 3'b000, DISP_CTRL[0]});

        repeat (16) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;
        compare_value("reset_ack", 32'h0, wbm_ack_o);
        compare_value("reset_an", 32'hf, an_o);
        finish_test("reset");

        for (int r = 0; r < t_name.size(); r++) begin
            bus_transfer(t_write[r], t_adr[r], t_sel[r], t_wdata[r], rdata, ok);
            if (!ok) begin
                test_errors++;
            end else if (!t_write[r]) begin
                compare_value(t_name[r], t_expect[r], rdata);
            end
            finish_test(t_name[r]);
        end

        // The control register still holds enable from the table
        check_scan();
        finish_test("scan_enabled");

        // Clearing enable must blank every anode
        bus_transfer(1'b1, `SEG7_ADDR + 1, 4'hf, 32'h0, rdata, ok);
        if (!ok) begin
            test_errors++;
        end
        repeat (2) @(negedge wb_clk_i);
        for (int c = 0; c < BLANK_CYCLES; c++) begin
            @(negedge wb_clk_i);
            if (an_o !== 4'hf && test_errors == 0) begin
                compare_value("scan_disabled", 32'hf, an_o);
            end
        end
        finish_test("scan_disabled");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/tenyr_bus_pkg.sv
hw/wb_mux.sv
hw/block_ram.sv
hw/seg7_regs.sv
hw/seg7_scan.sv
hw/tenyr_bus_top.sv
tb/tb_tenyr_bus.sv
